// ==== hw/adc_stream_params.svh ====
////////////////////////////////////////////////////////////////////////////
// ADC stream bridge defaults
// Sample and lane widths, channel count, buffer depth and burst length
// shared by the packer, buffer and AXI-stream framer.
////////////////////////////////////////////////////////////////////////////

`ifndef ADC_STREAM_PARAMS_SVH
`define ADC_STREAM_PARAMS_SVH

// converter sample and byte-aligned lane widths
`define ADC_SAMPLE_WIDTH 12
`define ADC_LANE_WIDTH   16

// four I/Q channels, two lanes each, 128-bit beat
`define ADC_CHANNELS     4

// buffering and framing defaults
`define ADC_FIFO_DEPTH   8
`define ADC_BURST_LENGTH 8

`endif

// ==== hw/adc_stream_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// ADC stream types
// Sample, channel-set and beat records plus the mode and state enums
// used across the receive path.
////////////////////////////////////////////////////////////////////////////

`include "adc_stream_params.svh"

package adc_stream_pkg;

  // one converter sample pair
  typedef struct packed {
    logic [`ADC_SAMPLE_WIDTH-1:0] i;
    logic [`ADC_SAMPLE_WIDTH-1:0] q;
  } iq_sample_t;

  // everything the converter delivers in one cycle, ch0 in the low bits
  typedef struct packed {
    logic [`ADC_CHANNELS-1:0] valid;
    iq_sample_t               ch3;
    iq_sample_t               ch2;
    iq_sample_t               ch1;
    iq_sample_t               ch0;
  } adc_channels_t;

  // 128-bit stream beat, lane0 is bits 15:0
  typedef struct packed {
    logic [`ADC_LANE_WIDTH-1:0] lane7;
    logic [`ADC_LANE_WIDTH-1:0] lane6;
    logic [`ADC_LANE_WIDTH-1:0] lane5;
    logic [`ADC_LANE_WIDTH-1:0] lane4;
    logic [`ADC_LANE_WIDTH-1:0] lane3;
    logic [`ADC_LANE_WIDTH-1:0] lane2;
    logic [`ADC_LANE_WIDTH-1:0] lane1;
    logic [`ADC_LANE_WIDTH-1:0] lane0;
  } axis_beat_t;

  typedef enum logic {VALID_ANY, VALID_ALL} valid_mode_e;
  typedef enum logic {LANE_ORDER_NATURAL, LANE_ORDER_REVERSED} lane_order_e;
  typedef enum logic {FRAMER_EMPTY, FRAMER_LOADED} framer_state_e;

endpackage

// ==== hw/iq_sample_packer.sv ====
////////////////////////////////////////////////////////////////////////////
// I/Q sample packer
// Registers the converter inputs, qualifies the valid strobes and packs
// eight sign-extended lanes into one beat with a single push pulse.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "adc_stream_params.svh"

module iq_sample_packer #(
  parameter adc_stream_pkg::valid_mode_e VALID_MODE = adc_stream_pkg::VALID_ANY,
  parameter adc_stream_pkg::lane_order_e LANE_ORDER = adc_stream_pkg::LANE_ORDER_NATURAL
) (
  input  logic                       m_axis_clk,
  input  logic                       rst_n,
  input  adc_stream_pkg::adc_channels_t samples,
  output logic                       push,
  output adc_stream_pkg::axis_beat_t push_beat
);

  localparam int EXT_W = `ADC_LANE_WIDTH - `ADC_SAMPLE_WIDTH;

  // replicate the sample msb into the upper lane bits
  function automatic logic [`ADC_LANE_WIDTH-1:0] sign_ext(
    input logic [`ADC_SAMPLE_WIDTH-1:0] s
  );
    sign_ext = {{EXT_W{s[`ADC_SAMPLE_WIDTH-1]}}, s};
  endfunction

  logic [`ADC_CHANNELS-1:0]   valid_q;
  adc_stream_pkg::iq_sample_t ch0_q;
  adc_stream_pkg::iq_sample_t ch1_q;
  adc_stream_pkg::iq_sample_t ch2_q;
  adc_stream_pkg::iq_sample_t ch3_q;
  logic                       qualified;
  adc_stream_pkg::axis_beat_t beat_d;

  // capture stage, valid strobes are control and get reset
  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= samples.valid;
    end
  end

  always_ff @(posedge m_axis_clk) begin
    ch0_q <= samples.ch0;
    ch1_q <= samples.ch1;
    ch2_q <= samples.ch2;
    ch3_q <= samples.ch3;
  end

  always_comb begin
    if (VALID_MODE == adc_stream_pkg::VALID_ALL) begin
      qualified = &valid_q;
    end else begin
      qualified = |valid_q;
    end
  end

  // lane placement
  always_comb begin
    if (LANE_ORDER == adc_stream_pkg::LANE_ORDER_REVERSED) begin
      beat_d.lane0 = sign_ext(ch0_q.i);
      beat_d.lane1 = sign_ext(ch0_q.q);
      beat_d.lane2 = sign_ext(ch1_q.i);
      beat_d.lane3 = sign_ext(ch1_q.q);
      beat_d.lane4 = sign_ext(ch2_q.i);
      beat_d.lane5 = sign_ext(ch2_q.q);
      beat_d.lane6 = sign_ext(ch3_q.i);
      beat_d.lane7 = sign_ext(ch3_q.q);
    end else begin
      // natural order puts q3 at the bottom and i0 at the top
      beat_d.lane0 = sign_ext(ch3_q.q);
      beat_d.lane1 = sign_ext(ch3_q.i);
      beat_d.lane2 = sign_ext(ch2_q.q);
      beat_d.lane3 = sign_ext(ch2_q.i);
      beat_d.lane4 = sign_ext(ch1_q.q);
      beat_d.lane5 = sign_ext(ch1_q.i);
      beat_d.lane6 = sign_ext(ch0_q.q);
      beat_d.lane7 = sign_ext(ch0_q.i);
    end
  end

  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      push <= 1'b0;
    end else begin
      push <= qualified;
    end
  end

  always_ff @(posedge m_axis_clk) begin
    if (qualified) begin
      push_beat <= beat_d;
    end
  end

endmodule

// ==== hw/beat_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// Beat buffer
// Circular store of packed beats with a combinational head. Pushes into a
// full buffer are dropped and raise a sticky overflow flag.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "adc_stream_params.svh"

module beat_fifo #(
  parameter int DEPTH = `ADC_FIFO_DEPTH
) (
  input  logic                       m_axis_clk,
  input  logic                       rst_n,
  input  logic                       push,
  input  adc_stream_pkg::axis_beat_t push_beat,
  input  logic                       pop,
  output logic                       not_empty,
  output adc_stream_pkg::axis_beat_t head_beat,
  output logic                       overflow
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  adc_stream_pkg::axis_beat_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full      = (count == CNT_W'(DEPTH));
  assign not_empty = (count != '0);
  assign wr_en     = push & ~full;
  assign rd_en     = pop & not_empty;
  assign head_beat = mem[rd_ptr];

  // explicit wrap so any depth works, not only powers of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      next_ptr = '0;
    end else begin
      next_ptr = p + 1'b1;
    end
  endfunction

  always_ff @(posedge m_axis_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= push_beat;
    end
  end

  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // occupancy follows the honored push and pop
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // sticky until reset
  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else if (push && full) begin
      overflow <= 1'b1;
    end
  end

endmodule

// ==== hw/axis_burst_framer.sv ====
////////////////////////////////////////////////////////////////////////////
// AXI-stream burst framer
// Owns the registered stream output, refills it from the buffer while the
// current beat is accepted and marks burst ends with tlast.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "adc_stream_params.svh"

module axis_burst_framer #(
  parameter bit USE_TLAST    = 1'b1,
  parameter int BURST_LENGTH = `ADC_BURST_LENGTH
) (
  input  logic                       m_axis_clk,
  input  logic                       rst_n,
  input  logic                       not_empty,
  input  adc_stream_pkg::axis_beat_t head_beat,
  output logic                       pop,
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output adc_stream_pkg::axis_beat_t m_axis_tdata,
  output logic                       m_axis_tlast
);

  adc_stream_pkg::framer_state_e state_q;
  logic                          accept;

  assign m_axis_tvalid = (state_q == adc_stream_pkg::FRAMER_LOADED);
  assign accept        = m_axis_tvalid & m_axis_tready;

  // refill when the register is free or leaving this cycle
  assign pop = not_empty & (~m_axis_tvalid | m_axis_tready);

  //////////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= adc_stream_pkg::FRAMER_EMPTY;
    end else begin
      case (state_q)
        adc_stream_pkg::FRAMER_EMPTY: begin
          if (pop) begin
            state_q <= adc_stream_pkg::FRAMER_LOADED;
          end
        end
        adc_stream_pkg::FRAMER_LOADED: begin
          if (accept && !pop) begin
            state_q <= adc_stream_pkg::FRAMER_EMPTY;
          end
        end
        default: state_q <= adc_stream_pkg::FRAMER_EMPTY;
      endcase
    end
  end

  // data only moves on a pop, so it holds under back-pressure
  always_ff @(posedge m_axis_clk) begin
    if (pop) begin
      m_axis_tdata <= head_beat;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // burst counter
  //////////////////////////////////////////////////////////////////////////

  if (USE_TLAST) begin : g_tlast
    localparam int CNT_W = (BURST_LENGTH > 1) ? $clog2(BURST_LENGTH) : 1;

    logic [CNT_W-1:0] beat_cnt;
    logic             end_burst;

    assign end_burst    = (beat_cnt == CNT_W'(BURST_LENGTH - 1));
    assign m_axis_tlast = m_axis_tvalid & end_burst;

    // counts accepted beats and wraps after the last of a burst
    always_ff @(posedge m_axis_clk or negedge rst_n) begin
      if (!rst_n) begin
        beat_cnt <= '0;
      end else if (accept) begin
        beat_cnt <= end_burst ? '0 : beat_cnt + 1'b1;
      end
    end
  end else begin : g_no_tlast
    assign m_axis_tlast = 1'b0;
  end

endmodule

// ==== hw/adc_axis_bridge.sv ====
////////////////////////////////////////////////////////////////////////////
// ADC to AXI-stream bridge
// Packer, beat buffer and burst framer on a single stream clock.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "adc_stream_params.svh"

module adc_axis_bridge #(
  parameter adc_stream_pkg::valid_mode_e VALID_MODE = adc_stream_pkg::VALID_ANY,
  parameter adc_stream_pkg::lane_order_e LANE_ORDER = adc_stream_pkg::LANE_ORDER_NATURAL,
  parameter int DEPTH        = `ADC_FIFO_DEPTH,
  parameter bit USE_TLAST    = 1'b1,
  parameter int BURST_LENGTH = `ADC_BURST_LENGTH
) (
  input  logic                          m_axis_clk,
  input  logic                          rst_n,
  input  adc_stream_pkg::adc_channels_t samples,
  output logic                          m_axis_tvalid,
  input  logic                          m_axis_tready,
  output adc_stream_pkg::axis_beat_t    m_axis_tdata,
  output logic                          m_axis_tlast,
  output logic                          overflow
);

  logic                       push;
  adc_stream_pkg::axis_beat_t push_beat;
  logic                       pop;
  logic                       not_empty;
  adc_stream_pkg::axis_beat_t head_beat;

  iq_sample_packer #(
    .VALID_MODE (VALID_MODE),
    .LANE_ORDER (LANE_ORDER)
  ) u_packer (
    .m_axis_clk (m_axis_clk),
    .rst_n      (rst_n),
    .samples    (samples),
    .push       (push),
    .push_beat  (push_beat)
  );

  beat_fifo #(
    .DEPTH (DEPTH)
  ) u_fifo (
    .m_axis_clk (m_axis_clk),
    .rst_n      (rst_n),
    .push       (push),
    .push_beat  (push_beat),
    .pop        (pop),
    .not_empty  (not_empty),
    .head_beat  (head_beat),
    .overflow   (overflow)
  );

  axis_burst_framer #(
    .USE_TLAST    (USE_TLAST),
    .BURST_LENGTH (BURST_LENGTH)
  ) u_framer (
    .m_axis_clk    (m_axis_clk),
    .rst_n         (rst_n),
    .not_empty     (not_empty),
    .head_beat     (head_beat),
    .pop           (pop),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

// ==== bench/tb_checks.svh ====
////////////////////////////////////////////////////////////////////////////
// Testbench compare tasks
// Typed checks for beats, flags and counts with shared error counters.
////////////////////////////////////////////////////////////////////////////

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int error_count = 0;
int check_total = 0;

task automatic check_beat(input adc_stream_pkg::axis_beat_t got,
                          input adc_stream_pkg::axis_beat_t exp,
                          input string what);
  check_total++;
  if (got !== exp) begin
    error_count++;
    $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  check_total++;
  if (got !== exp) begin
    error_count++;
    $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
  end
endtask

task automatic check_count(input int got, input int exp, input string what);
  check_total++;
  if (got != exp) begin
    error_count++;
    $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
  end
endtask

// failures that are not a wrong value
task automatic report_failure(input string what);
  error_count++;
  $display("ERROR at %0t: %s", $time, what);
endtask

`endif

// ==== bench/tb_adc_axis_bridge.sv ====
////////////////////////////////////////////////////////////////////////////
// ADC to AXI-stream bridge testbench
// Table-driven captures under ready-high, random and stalled tready with
// a scoreboard queue of expected beats and burst tlast checks.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "adc_stream_params.svh"

module tb_adc_axis_bridge #(
  parameter int TB_VALID_MODE = 0,
  parameter int TB_LANE_ORDER = 0,
  parameter int TB_USE_TLAST  = 1
);

  localparam int DEPTH         = `ADC_FIFO_DEPTH;
  localparam int BURST_LENGTH  = `ADC_BURST_LENGTH;
  localparam int NUM_DIRECTED  = 10;
  localparam int NUM_RANDOM    = 24;
  localparam int NUM_OVERFLOW  = 12;
  localparam int NUM_ROWS      = NUM_DIRECTED + NUM_RANDOM + NUM_OVERFLOW;
  localparam int DRAIN_TIMEOUT = 400;
  localparam int QUIET_CYCLES  = 16;

  // min, max, -1 and a few ordinary values rotated across the rows
  localparam logic [11:0] EXTREMES [8] = '{12'h800, 12'h7ff, 12'hfff, 12'h001,
                                           12'h123, 12'habc, 12'h000, 12'h400};
  localparam logic [3:0] DIRECTED_VALID [NUM_DIRECTED] = '{4'hf, 4'hf, 4'h1, 4'h0,
    4'h8, 4'hf, 4'h6, 4'h0, 4'hf, 4'hf};

  typedef enum logic [1:0] {READY_HIGH, READY_RANDOM, READY_LOW} ready_tag_e;

  typedef struct packed {
    adc_stream_pkg::adc_channels_t chans;
    ready_tag_e                    ready;
    logic                          any_ok;
    logic                          all_ok;
  } stim_row_t;

  logic                          m_axis_clk;
  logic                          rst_n;
  adc_stream_pkg::adc_channels_t samples;
  logic                          m_axis_tvalid;
  logic                          m_axis_tready;
  adc_stream_pkg::axis_beat_t    m_axis_tdata;
  logic                          m_axis_tlast;
  logic                          overflow;

  stim_row_t                  stim_table [NUM_ROWS];
  adc_stream_pkg::axis_beat_t expected_q [$];
  ready_tag_e                 ready_mode;
  int                         accepted_count = 0;
  int                         beat_idx = 0;
  logic                       stall_q = 1'b0;
  adc_stream_pkg::axis_beat_t held_data;
  logic                       held_last;

  `include "tb_checks.svh"

  adc_axis_bridge #(
    .VALID_MODE   (adc_stream_pkg::valid_mode_e'(TB_VALID_MODE)),
    .LANE_ORDER   (adc_stream_pkg::lane_order_e'(TB_LANE_ORDER)),
    .DEPTH        (DEPTH),
    .USE_TLAST    (TB_USE_TLAST != 0),
    .BURST_LENGTH (BURST_LENGTH)
  ) u_dut (
    .m_axis_clk    (m_axis_clk),
    .rst_n         (rst_n),
    .samples       (samples),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .overflow      (overflow)
  );

  initial begin
    m_axis_clk = 1'b0;
    forever #4 m_axis_clk = ~m_axis_clk;
  end

  // ready pattern
  always @(posedge m_axis_clk) begin
    case (ready_mode)
      READY_HIGH:   m_axis_tready <= 1'b1;
      READY_RANDOM: m_axis_tready <= 1'($urandom);
      default:      m_axis_tready <= 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // monitor and scoreboard
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge m_axis_clk) begin
    if (!rst_n) begin
      beat_idx = 0;
      stall_q  = 1'b0;
    end else begin
      if (stall_q) begin
        check_beat(m_axis_tdata, held_data, "tdata held under back-pressure");
        check_flag(m_axis_tlast, held_last, "tlast held under back-pressure");
      end
      if (m_axis_tvalid && m_axis_tready) begin
        if (expected_q.size() == 0) begin
          report_failure("beat accepted while none was expected");
        end else begin
          check_beat(m_axis_tdata, expected_q.pop_front(), "beat data");
        end
        check_flag(m_axis_tlast, (TB_USE_TLAST != 0) &&
                   (beat_idx % BURST_LENGTH == BURST_LENGTH - 1), "tlast");
        beat_idx++;
        accepted_count++;
      end
      stall_q   = m_axis_tvalid && !m_axis_tready;
      held_data = m_axis_tdata;
      held_last = m_axis_tlast;
    end
  end

  function automatic logic [15:0] lane_of(input logic [11:0] s);
    return 16'($signed(s));
  endfunction

  // lane7 is the msb of the concatenation
  function automatic adc_stream_pkg::axis_beat_t expected_beat(
    input adc_stream_pkg::adc_channels_t c
  );
    if (TB_LANE_ORDER != 0) begin
      return {lane_of(c.ch3.q), lane_of(c.ch3.i), lane_of(c.ch2.q), lane_of(c.ch2.i),
              lane_of(c.ch1.q), lane_of(c.ch1.i), lane_of(c.ch0.q), lane_of(c.ch0.i)};
    end
    return {lane_of(c.ch0.i), lane_of(c.ch0.q), lane_of(c.ch1.i), lane_of(c.ch1.q),
            lane_of(c.ch2.i), lane_of(c.ch2.q), lane_of(c.ch3.i), lane_of(c.ch3.q)};
  endfunction

  function automatic logic qualifies(input stim_row_t r);
    return (TB_VALID_MODE != 0) ? r.all_ok : r.any_ok;
  endfunction

  function automatic stim_row_t make_row(input logic [3:0] valid,
                                         input logic [7:0][11:0] v,
                                         input ready_tag_e tag);
    stim_row_t r;
    r.chans.valid = valid;
    r.chans.ch0   = '{i: v[0], q: v[1]};
    r.chans.ch1   = '{i: v[2], q: v[3]};
    r.chans.ch2   = '{i: v[4], q: v[5]};
    r.chans.ch3   = '{i: v[6], q: v[7]};
    r.ready       = tag;
    r.any_ok      = |valid;
    r.all_ok      = &valid;
    return r;
  endfunction

  // directed rows, then random back-pressure rows, then the overflow burst
  task automatic build_table();
    logic [7:0][11:0] v;
    for (int k = 0; k < NUM_ROWS; k++) begin
      for (int j = 0; j < 8; j++) begin
        v[j] = (k < NUM_DIRECTED) ? EXTREMES[(j + k) % 8] : 12'($urandom);
      end
      if (k < NUM_DIRECTED) begin
        stim_table[k] = make_row(DIRECTED_VALID[k], v, READY_HIGH);
      end else if (k < NUM_DIRECTED + NUM_RANDOM) begin
        stim_table[k] = make_row(4'($urandom_range(0, 15)), v, READY_RANDOM);
      end else begin
        stim_table[k] = make_row(4'hf, v, READY_LOW);
      end
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("test %-26s %s, %0d errors", name,
             (error_count == start_errors) ? "ok" : "FAILED", error_count - start_errors);
  endtask

  task automatic apply_reset();
    @(posedge m_axis_clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge m_axis_clk);
    @(negedge m_axis_clk);
    check_flag(m_axis_tvalid, 1'b0, "tvalid in reset");
    check_flag(m_axis_tlast, 1'b0, "tlast in reset");
    check_flag(overflow, 1'b0, "overflow in reset");
    repeat (2) @(posedge m_axis_clk);
    rst_n <= 1'b1;
  endtask

  task automatic wait_drain(input string name);
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
      @(negedge m_axis_clk);
      cycles++;
    end
    if (expected_q.size() != 0) begin
      report_failure($sformatf("timeout waiting for tvalid in test %s", name));
      expected_q.delete();
    end
    // late extra beats show up as unexpected in the monitor
    repeat (QUIET_CYCLES) @(negedge m_axis_clk);
  endtask

  task automatic run_rows(input int first, input int count, input int keep,
                          input logic exp_overflow, input string name);
    int start_errors;
    int start_accepted;
    int expected_beats;
    start_errors   = error_count;
    start_accepted = accepted_count;
    expected_beats = 0;
    for (int r = first; r < first + count; r++) begin
      @(posedge m_axis_clk);
      samples    <= stim_table[r].chans;
      ready_mode <= stim_table[r].ready;
      if (qualifies(stim_table[r]) && expected_beats < keep) begin
        expected_q.push_back(expected_beat(stim_table[r].chans));
        expected_beats++;
      end
      // at most one capture every other cycle under random ready
      if (stim_table[r].ready == READY_RANDOM) begin
        @(posedge m_axis_clk);
        samples.valid <= '0;
      end
    end
    @(posedge m_axis_clk);
    samples.valid <= '0;
    repeat (4) @(posedge m_axis_clk);
    ready_mode <= READY_HIGH;
    wait_drain(name);
    check_count(accepted_count - start_accepted, expected_beats, {name, " beat count"});
    check_flag(overflow, exp_overflow, {name, " overflow"});
    report_test(name, start_errors);
  endtask

  initial begin
    int start_errors;
    void'($urandom(96998));
    rst_n         = 1'b0;
    samples       = '0;
    m_axis_tready = 1'b0;
    ready_mode    = READY_HIGH;
    build_table();

    start_errors = error_count;
    apply_reset();
    repeat (4) @(negedge m_axis_clk);
    check_flag(m_axis_tvalid, 1'b0, "tvalid after reset");
    check_flag(m_axis_tlast, 1'b0, "tlast after reset");
    check_flag(overflow, 1'b0, "overflow after reset");
    report_test("reset", start_errors);

    run_rows(0, NUM_DIRECTED, NUM_ROWS, 1'b0, "packing and qualification");
    run_rows(NUM_DIRECTED, NUM_RANDOM, NUM_ROWS, 1'b0, "back-pressure");
    run_rows(NUM_DIRECTED + NUM_RANDOM, NUM_OVERFLOW, DEPTH + 1, 1'b1, "overflow");

    start_errors = error_count;
    apply_reset();
    @(negedge m_axis_clk);
    check_flag(overflow, 1'b0, "overflow cleared by reset");
    report_test("overflow clear", start_errors);

    $display("checks %0d, errors %0d", check_total, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+hw
+incdir+bench
hw/adc_stream_pkg.sv
hw/iq_sample_packer.sv
hw/beat_fifo.sv
hw/axis_burst_framer.sv
hw/adc_axis_bridge.sv
bench/tb_adc_axis_bridge.sv

// ==== Makefile ====
# Verilator build and run for the ADC to AXI-stream bridge

VERILATOR  ?= verilator
TOP        ?= tb_adc_axis_bridge
VALID_MODE ?= 0
LANE_ORDER ?= 0
USE_TLAST  ?= 1
CONFIG     := $(VALID_MODE)$(LANE_ORDER)$(USE_TLAST)
BUILD_DIR  ?= obj_dir_$(CONFIG)
LOG        ?= sim_$(CONFIG).log
VFLAGS     ?= --binary --timing -j 0
GFLAGS     := -GTB_VALID_MODE=$(VALID_MODE) -GTB_LANE_ORDER=$(LANE_ORDER) \
              -GTB_USE_TLAST=$(USE_TLAST)

SOURCES := $(shell grep -v '^+' project.f)
HEADERS := hw/adc_stream_params.svh bench/tb_checks.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run sweep clean

all: run

$(SIM_BIN): project.f $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) $(GFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f project.f

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "Done: errors found" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "FAILED, see $(LOG)"; exit 1; fi

sweep:
	$(MAKE) run VALID_MODE=0 LANE_ORDER=0 USE_TLAST=1
	$(MAKE) run VALID_MODE=1 LANE_ORDER=1 USE_TLAST=1
	$(MAKE) run VALID_MODE=0 LANE_ORDER=0 USE_TLAST=0

clean:
	rm -rf obj_dir_* sim_*.log
